// File: graphics.f
source/vga_pkg.sv
source/game_pkg.sv
source/vga_timing.sv
source/player_sprite.sv
source/screen_sequencer.sv
source/pixel_mixer.sv
source/graphics.sv
sim/graphics_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the graphics testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f graphics.f \
	--top-module graphics_tb -o graphics_sim &&
	./obj_dir/graphics_sim > sim.log 2>&1
cat sim.log 2> /dev/null

grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation PASSED"

// File: sim/graphics_tb.sv
`timescale 1ns/1ps

module graphics_tb;

	import vga_pkg::*;
	import game_pkg::*;

	localparam int H_ACTIVE = 16;	// Tiny raster
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 2;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 12;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 1;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;	// 22 clocks per line
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;	// 15 lines per frame
	localparam int MARKER_SIZE = 3;
	localparam int PLAY_FRAMES = 4;
	localparam int SNITCH_FRAMES = 1;
	localparam int SNITCH_X = 6;	// Snitch square, inside the raster
	localparam int SNITCH_Y = 4;
	localparam int SNITCH_SIZE = 3;
	localparam int TIMEOUT = 12 * H_TOTAL * V_TOTAL + 200;	// Test runs about ten frames
	localparam int ACK_WAIT = 16;	// Handshake cycles allowed
	localparam logic [31:0] SEED = 32'h8824a3f8;

	typedef struct packed {
		rgb_t rgb;
		logic hs;
		logic vs;
		logic blank;
	} video_t;	// Everything the monitor sees

	logic clock = 1'b0;
	logic reset;
	player_in_t player_1;
	player_in_t player_2;
	logic two_player_mode;
	logic cmd_req;
	screen_e cmd_screen;
	logic cmd_ack;
	rgb_t rgb;
	logic hs;
	logic vs;
	logic blank;

	int px;	// Model pixel column
	int py;	// Model pixel row
	int cycles = 0;
	int errors = 0;
	int snitch_px = 0;	// Gold pixels seen at rgb
	int times_up_px = 0;	// Times-up pixels seen at rgb
	screen_e ref_screen;	// Screen as the host and timer set it
	int ref_frames;	// Play frames passed
	logic ref_ack;
	video_t hist [2];	// Expected outputs, two pixels in flight

	graphics #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.NUM_PLAYERS(2), .MARKER_SIZE(MARKER_SIZE),
		.PLAY_FRAMES(PLAY_FRAMES), .SNITCH_FRAMES(SNITCH_FRAMES),
		.SNITCH_X(SNITCH_X), .SNITCH_Y(SNITCH_Y), .SNITCH_SIZE(SNITCH_SIZE)
	) i_graphics (
		.clock(clock), .reset(reset), .player_1(player_1), .player_2(player_2),
		.two_player_mode(two_player_mode), .cmd_req(cmd_req), .cmd_screen(cmd_screen),
		.cmd_ack(cmd_ack), .rgb(rgb), .hs(hs), .vs(vs), .blank(blank)
	);

	always #2 clock = ~clock;	// 4 ns period

	task automatic stop_failed();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("[FAIL] %0t %s: got %0h expected %0h", $time, what, got, want);
			stop_failed();
		end
	endtask

	function automatic rgb_t background(input screen_e scr);
		case (scr)
			SCR_LOGO: return 24'h202060;	// Navy
			SCR_READY: return 24'h00a0a0;	// Teal
			SCR_PLAY: return 24'h104010;	// Pitch green
			SCR_TIMES_UP: return 24'ha02020;	// Dark red
			default: return 24'h404040;	// Board grey
		endcase
	endfunction

	// House colour, G before S before H before R
	function automatic rgb_t marker_color(input house_keys_t keys);
		if (keys.g) return 24'hff0000;
		if (keys.s) return 24'h00ff00;
		if (keys.h) return 24'hffff00;
		if (keys.r) return 24'h0000ff;
		return 24'hffffff;	// No house
	endfunction

	function automatic logic in_square(input int x, input int y, input int x0, input int y0,
		input int size);
		return x >= x0 && x < x0 + size && y >= y0 && y < y0 + size;
	endfunction

	// Monitor output for one raster position
	function automatic video_t expected_video(input int x, input int y, input screen_e scr,
		input logic snitch, input player_in_t p1, input player_in_t p2, input logic p2_on);
		video_t v;
		logic visible;
		visible = x < H_ACTIVE && y < V_ACTIVE;
		v.hs = !(x >= H_ACTIVE + H_FRONT && x < H_ACTIVE + H_FRONT + H_SYNC);	// Active low
		v.vs = !(y >= V_ACTIVE + V_FRONT && y < V_ACTIVE + V_FRONT + V_SYNC);
		v.blank = visible;
		v.rgb = background(scr);
		if (!visible) begin
			v.rgb = '0;	// Black in porches
		end else if (scr == SCR_PLAY) begin
			if (snitch && in_square(x, y, SNITCH_X, SNITCH_Y, SNITCH_SIZE)) begin
				v.rgb = 24'hffd700;	// Gold on top
			end else if (in_square(x, y, int'(p1.reading[7:0]), int'(p1.reading[15:8]),
				MARKER_SIZE)) begin
				v.rgb = marker_color(p1.keys);	// Player 1 over player 2
			end else if (p2_on && in_square(x, y, int'(p2.reading[7:0]),
				int'(p2.reading[15:8]), MARKER_SIZE)) begin
				v.rgb = marker_color(p2.keys);
			end
		end
		return v;
	endfunction

	function automatic player_in_t make_player(input int col, input int row,
		input logic [3:0] keys);
		player_in_t p;
		p.reading = {row[7:0], col[7:0]};	// Row in high byte
		p.keys = keys;	// g, s, h, r from MSB
		return p;
	endfunction

	function automatic player_in_t random_player();
		return make_player(int'($urandom_range(H_ACTIVE - 1, 0)),
			int'($urandom_range(V_ACTIVE - 1, 0)), 4'($urandom));
	endfunction

	// Raster counters from reset
	always @(posedge clock) begin
		if (reset) begin
			px <= 0;
			py <= 0;
		end else if (px == H_TOTAL - 1) begin
			px <= 0;
			py <= (py == V_TOTAL - 1) ? 0 : py + 1;	// Next line or next frame
		end else begin
			px <= px + 1;
		end
	end

	// Compare outputs with the model, then step the model
	always @(posedge clock) begin
		video_t now;
		logic snitch_now;
		if (reset) begin
			ref_screen = SCR_LOGO;
			ref_frames = 0;
			ref_ack = 1'b0;
			hist[1] = '{rgb: '0, hs: 1'b1, vs: 1'b1, blank: 1'b1};	// Output registers in reset
			hist[0] = expected_video(0, 0, SCR_LOGO, 1'b0, '0, '0, 1'b0);	// Pixel held in reset
		end else begin
			check_value("rgb", rgb, hist[1].rgb);
			check_value("hs", hs, hist[1].hs);
			check_value("vs", vs, hist[1].vs);
			check_value("blank", blank, hist[1].blank);
			check_value("cmd_ack", cmd_ack, ref_ack);
			if (blank && rgb == 24'hffd700) snitch_px++;	// Gold at the output
			if (blank && rgb == background(SCR_TIMES_UP)) times_up_px++;
			snitch_now = ref_screen == SCR_PLAY && ref_frames >= PLAY_FRAMES - SNITCH_FRAMES;
			now = expected_video(px, py, ref_screen, snitch_now, player_1, player_2,
				two_player_mode);
			hist[1] = hist[0];
			hist[0] = now;
			if (cmd_req && !ref_ack) begin
				ref_screen = cmd_screen;	// Host wins, timer restarts
				ref_frames = 0;
			end else if (ref_screen == SCR_PLAY && px == 0 && py == 0) begin
				ref_frames = ref_frames + 1;	// One more play frame
				if (ref_frames == PLAY_FRAMES) begin
					ref_screen = SCR_TIMES_UP;
					ref_frames = 0;
				end
			end
			if (!ref_ack && cmd_req) begin
				ref_ack = 1'b1;
			end else if (ref_ack && !cmd_req) begin
				ref_ack = 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			stop_failed();
		end
	end

	// Returns on the edge that starts pixel 0,0
	task automatic wait_frame_end();
		@(posedge clock);
		while (!(px == H_TOTAL - 1 && py == V_TOTAL - 1)) begin
			@(posedge clock);
		end
	endtask

	// Four-phase exchange from the host side
	task automatic host_command(input screen_e scr);
		int waited;
		if (cmd_ack !== 1'b0) begin
			$display("cmd_ack was high before a new request");
			stop_failed();
		end
		cmd_screen <= scr;
		cmd_req <= 1'b1;
		waited = 0;
		@(posedge clock);
		while (cmd_ack !== 1'b1 && waited < ACK_WAIT) begin
			@(posedge clock);
			waited++;
		end
		if (cmd_ack !== 1'b1) begin
			$display("cmd_ack did not rise after cmd_req");
			stop_failed();
		end
		cmd_req <= 1'b0;
		@(posedge clock);
		if (cmd_ack !== 1'b1) begin
			$display("cmd_ack fell while cmd_req was still high");
			stop_failed();
		end
		waited = 0;
		while (cmd_ack !== 1'b0 && waited < ACK_WAIT) begin
			@(posedge clock);
			waited++;
		end
		if (cmd_ack !== 1'b0) begin
			$display("cmd_ack did not fall after cmd_req dropped");
			stop_failed();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		player_1 = '0;
		player_2 = '0;
		two_player_mode = 1'b0;
		cmd_req = 1'b0;
		cmd_screen = SCR_LOGO;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		wait_frame_end();	// Frame 0 is the logo from reset
		host_command(SCR_BOARD);
		wait_frame_end();
		host_command(SCR_LOGO);
		wait_frame_end();
		player_1 <= make_player(2, 3, 4'b0000);	// White
		player_2 <= make_player(10, 7, 4'b0010);	// Yellow
		two_player_mode <= 1'b1;
		host_command(SCR_PLAY);
		wait_frame_end();
		player_1 <= make_player(5, 5, 4'b0111);	// S beats H and R
		player_2 <= make_player(6, 6, 4'b1000);	// Overlap
		wait_frame_end();
		two_player_mode <= 1'b0;	// Player 2 hidden
		wait_frame_end();
		player_1 <= random_player();	// Snitch frame
		player_2 <= random_player();
		two_player_mode <= 1'b1;
		wait_frame_end();	// Times up by the timer
		wait_frame_end();
		host_command(SCR_PLAY);
		wait_frame_end();
		host_command(SCR_BOARD);	// Override mid-round
		wait_frame_end();
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_value("snitch pixels", snitch_px, SNITCH_SIZE * SNITCH_SIZE);
		check_value("times-up pixels", times_up_px, H_ACTIVE * V_ACTIVE);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: source/graphics.sv
`timescale 1ns/1ps

module graphics #(
	parameter int H_ACTIVE = 640,	// Raster, 640x480 by default
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int NUM_PLAYERS = 2,	// Renderer copies
	parameter int MARKER_SIZE = 8,
	parameter int PLAY_FRAMES = 3600,	// 60 s at 60 Hz
	parameter int SNITCH_FRAMES = 600,	// Last 10 s
	parameter int SNITCH_X = 312,
	parameter int SNITCH_Y = 232,
	parameter int SNITCH_SIZE = 16
) (
	input logic clock,
	input logic reset,
	input game_pkg::player_in_t player_1,
	input game_pkg::player_in_t player_2,	// Also feeds players past the second
	input logic two_player_mode,	// Second marker on
	input logic cmd_req,
	input game_pkg::screen_e cmd_screen,
	output logic cmd_ack,
	output vga_pkg::rgb_t rgb,
	output logic hs,
	output logic vs,
	output logic blank
);

	import vga_pkg::*;
	import game_pkg::*;

	pixel_pos_t pos;	// Shared raster position
	sprite_t sprites [NUM_PLAYERS];	// One per renderer
	screen_e screen;
	logic snitch_on;

	vga_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) i_vga_timing (.clock(clock), .reset(reset), .pos(pos));

	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
		player_sprite #(.MARKER_SIZE(MARKER_SIZE)) i_player_sprite (
			.clock(clock),
			.reset(reset),
			.pos(pos),
			.player(i == 0 ? player_1 : player_2),
			.enable(i == 0 ? 1'b1 : two_player_mode),	// Player 1 always shown
			.sprite(sprites[i])
		);
	end

	screen_sequencer #(.PLAY_FRAMES(PLAY_FRAMES), .SNITCH_FRAMES(SNITCH_FRAMES)) i_sequencer (
		.clock(clock), .reset(reset), .pos(pos),
		.cmd_req(cmd_req), .cmd_screen(cmd_screen), .cmd_ack(cmd_ack),
		.screen(screen), .snitch_on(snitch_on)
	);

	pixel_mixer #(
		.NUM_PLAYERS(NUM_PLAYERS), .SNITCH_X(SNITCH_X), .SNITCH_Y(SNITCH_Y),
		.SNITCH_SIZE(SNITCH_SIZE)
	) i_mixer (
		.clock(clock), .reset(reset), .pos(pos), .sprites(sprites),
		.screen(screen), .snitch_on(snitch_on),
		.rgb(rgb), .hs(hs), .vs(vs), .blank(blank)
	);

endmodule

// File: source/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer #(
	parameter int NUM_PLAYERS = 2,
	parameter int SNITCH_X = 312,	// Snitch top-left column
	parameter int SNITCH_Y = 232,	// Snitch top-left row
	parameter int SNITCH_SIZE = 16
) (
	input logic clock,
	input logic reset,
	input vga_pkg::pixel_pos_t pos,	// Same pixel the sprites saw
	input game_pkg::sprite_t sprites [NUM_PLAYERS],	// One stage behind pos
	input game_pkg::screen_e screen,
	input logic snitch_on,
	output vga_pkg::rgb_t rgb,	// Two stages behind pos
	output logic hs,
	output logic vs,
	output logic blank	// Low while blanking
);

	import vga_pkg::*;
	import game_pkg::*;

	localparam coord_t SX0 = coord_t'(SNITCH_X);
	localparam coord_t SX1 = coord_t'(SNITCH_X + SNITCH_SIZE);
	localparam coord_t SY0 = coord_t'(SNITCH_Y);
	localparam coord_t SY1 = coord_t'(SNITCH_Y + SNITCH_SIZE);

	pixel_pos_t pos_d;	// Aligned with sprite registers
	screen_e screen_d;
	logic snitch_d;
	logic snitch_hit;	// Pixel inside snitch square
	rgb_t pixel;	// Next output colour

	always_ff @(posedge clock) begin
		pos_d <= pos;	// Payload delay
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			screen_d <= SCR_LOGO;
			snitch_d <= 1'b0;
		end else begin
			screen_d <= screen;	// Keeps screen change two clocks from rgb
			snitch_d <= snitch_on;
		end
	end

	assign snitch_hit = snitch_d && (pos_d.x >= SX0) && (pos_d.x < SX1) &&
		(pos_d.y >= SY0) && (pos_d.y < SY1);

	// Layering, snitch on top, then lowest player index
	always_comb begin
		pixel = screen_color(screen_d);	// Background
		if (screen_d == SCR_PLAY) begin
			for (int i = NUM_PLAYERS - 1; i >= 0; i--) begin
				if (sprites[i].hit) pixel = sprites[i].color;	// Lower index overwrites
			end
			if (snitch_hit) pixel = SNITCH_GOLD;
		end
		if (!pos_d.active) pixel = RGB_BLACK;	// Porches and sync
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rgb <= RGB_BLACK;
			hs <= 1'b1;	// Sync idle
			vs <= 1'b1;
			blank <= 1'b1;
		end else begin
			rgb <= pixel;
			hs <= pos_d.hs;
			vs <= pos_d.vs;
			blank <= pos_d.active;
		end
	end

endmodule

// File: source/screen_sequencer.sv
`timescale 1ns/1ps

module screen_sequencer #(
	parameter int PLAY_FRAMES = 3600,	// Round length in frames
	parameter int SNITCH_FRAMES = 600	// Snitch shown for the last frames
) (
	input logic clock,
	input logic reset,
	input vga_pkg::pixel_pos_t pos,	// Only frame_start used
	input logic cmd_req,	// Host request
	input game_pkg::screen_e cmd_screen,	// Held while cmd_req high
	output logic cmd_ack,
	output game_pkg::screen_e screen,	// Current screen
	output logic snitch_on	// Snitch power-up visible
);

	import game_pkg::*;

	localparam int CNT_W = $clog2(PLAY_FRAMES + 1);
	localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(PLAY_FRAMES - 1);
	localparam logic [CNT_W-1:0] SNITCH_START = CNT_W'(PLAY_FRAMES - SNITCH_FRAMES);

	typedef enum logic {
		IDLE,	// Waiting for cmd_req
		ACKED	// Waiting for cmd_req to drop
	} state_e;

	state_e state;
	logic accept;	// Command taken this cycle
	logic [CNT_W-1:0] frame_cnt;	// Frames since entering play

	assign accept = (state == IDLE) && cmd_req;

	// Four-phase handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (cmd_req) state <= ACKED;
				ACKED: if (!cmd_req) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign cmd_ack = (state == ACKED);	// Rises with the screen load

	// Screen register and play timer
	always_ff @(posedge clock) begin
		if (reset) begin
			screen <= SCR_LOGO;
			frame_cnt <= '0;
		end else if (accept) begin
			screen <= cmd_screen;	// Host wins over timer
			frame_cnt <= '0;
		end else if (screen != SCR_PLAY) begin
			frame_cnt <= '0;	// Timer idle off play
		end else if (pos.frame_start) begin
			if (frame_cnt == LAST_FRAME) begin
				screen <= SCR_TIMES_UP;	// Round over
				frame_cnt <= '0;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	assign snitch_on = (screen == SCR_PLAY) && (frame_cnt >= SNITCH_START);

	// Ack released only once the host has let go
	assert property (@(posedge clock) disable iff (reset) $fell(cmd_ack) |-> !$past(cmd_req))
	else $error("screen_sequencer cmd_ack fell while cmd_req high");

endmodule

// File: source/player_sprite.sv
`timescale 1ns/1ps

module player_sprite #(
	parameter int MARKER_SIZE = 8	// Square edge in pixels
) (
	input logic clock,
	input logic reset,
	input vga_pkg::pixel_pos_t pos,	// Current raster position
	input game_pkg::player_in_t player,	// Wand reading and keys
	input logic enable,	// Marker shown
	output game_pkg::sprite_t sprite	// One stage behind pos
);

	import vga_pkg::*;
	import game_pkg::*;

	localparam coord_t SIZE = coord_t'(MARKER_SIZE);

	house_e house;	// Decoded key choice
	coord_t left;	// Marker top-left column
	coord_t top;	// Marker top-left row
	logic in_x;	// Column within square
	logic in_y;	// Row within square
	logic hit_d;	// Next hit
	logic hit_q;
	rgb_t color_q;	// House colour, no reset

	// Priority G, S, H, R
	always_comb begin
		if (player.keys.g) begin
			house = HOUSE_G;
		end else if (player.keys.s) begin
			house = HOUSE_S;
		end else if (player.keys.h) begin
			house = HOUSE_H;
		end else if (player.keys.r) begin
			house = HOUSE_R;
		end else begin
			house = HOUSE_NONE;	// White marker
		end
	end

	assign left = coord_t'(player.reading[7:0]);	// Low byte column
	assign top = coord_t'(player.reading[15:8]);	// High byte row
	assign in_x = (pos.x >= left) && (pos.x < left + SIZE);
	assign in_y = (pos.y >= top) && (pos.y < top + SIZE);
	assign hit_d = enable && pos.active && in_x && in_y;

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= hit_d;
		end
	end

	always_ff @(posedge clock) begin
		color_q <= house_color(house);	// Looked up every pixel
	end

	assign sprite.hit = hit_q;
	assign sprite.color = color_q;

	// Registered hit traces back to a visible pixel
	assert property (@(posedge clock) disable iff (reset) $rose(sprite.hit) |-> $past(pos.active))
	else $error("player_sprite hit outside active area");

endmodule

// File: source/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 640,	// Visible columns
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,	// Visible rows
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic clock,
	input logic reset,
	output vga_pkg::pixel_pos_t pos	// Combinational from counters
);

	import vga_pkg::*;

	// Window edges in counter width
	localparam coord_t H_VIS_END = coord_t'(H_ACTIVE);
	localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
	localparam coord_t H_SYNC_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coord_t H_LAST = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam coord_t V_VIS_END = coord_t'(V_ACTIVE);
	localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
	localparam coord_t V_SYNC_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam coord_t V_LAST = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

	coord_t x_q;	// Column counter
	coord_t y_q;	// Row counter
	logic line_end;	// Last column of a line

	assign line_end = (x_q == H_LAST);

	always_ff @(posedge clock) begin
		if (reset) begin
			x_q <= '0;	// Start at top-left
			y_q <= '0;
		end else if (line_end) begin
			x_q <= '0;	// Wrap column
			if (y_q == V_LAST) begin
				y_q <= '0;	// Wrap frame
			end else begin
				y_q <= y_q + 1'b1;
			end
		end else begin
			x_q <= x_q + 1'b1;
		end
	end

	always_comb begin
		pos.x = x_q;
		pos.y = y_q;
		pos.active = (x_q < H_VIS_END) && (y_q < V_VIS_END);
		pos.hs = !((x_q >= H_SYNC_START) && (x_q < H_SYNC_END));	// Low in sync window
		pos.vs = !((y_q >= V_SYNC_START) && (y_q < V_SYNC_END));
		pos.frame_start = (x_q == '0) && (y_q == '0);	// One pulse per frame
	end

	// Column counter never passes the line total
	assert property (@(posedge clock) disable iff (reset) x_q <= H_LAST)
	else $error("vga_timing column counter out of range");

	// Frame pulse only where the last row wraps back to row zero
	assert property (@(posedge clock) disable iff (reset)
		$rose(pos.frame_start) |-> $past(line_end) && ($past(y_q) == V_LAST))
	else $error("vga_timing frame_start without a frame wrap");

endmodule

// File: source/game_pkg.sv
package game_pkg;

	typedef enum logic [2:0] {
		SCR_LOGO,	// Power-up screen
		SCR_READY,	// Get ready
		SCR_PLAY,	// Markers and snitch visible
		SCR_TIMES_UP,	// Entered by the play timer too
		SCR_BOARD	// Leaderboard
	} screen_e;

	typedef enum logic [2:0] {
		HOUSE_NONE,	// No key held, white marker
		HOUSE_G,
		HOUSE_S,
		HOUSE_H,
		HOUSE_R
	} house_e;

	typedef struct packed {
		logic g;	// Highest priority
		logic s;
		logic h;
		logic r;	// Lowest priority
	} house_keys_t;

	typedef logic [15:0] ir_reading_t;	// [7:0] column, [15:8] row

	typedef struct packed {
		ir_reading_t reading;	// Wand position
		house_keys_t keys;	// Colour buttons
	} player_in_t;	// 20 bits

	typedef struct packed {
		logic hit;	// Pixel inside marker
		vga_pkg::rgb_t color;	// Marker colour
	} sprite_t;	// 25 bits

	localparam vga_pkg::rgb_t SNITCH_GOLD = '{r: 8'hff, g: 8'hd7, b: 8'h00};

	function automatic vga_pkg::rgb_t house_color(input house_e house);
		case (house)
			HOUSE_G: return '{r: 8'hff, g: 8'h00, b: 8'h00};	// Red
			HOUSE_S: return '{r: 8'h00, g: 8'hff, b: 8'h00};	// Green
			HOUSE_H: return '{r: 8'hff, g: 8'hff, b: 8'h00};	// Yellow
			HOUSE_R: return '{r: 8'h00, g: 8'h00, b: 8'hff};	// Blue
			default: return vga_pkg::RGB_WHITE;	// No house chosen
		endcase
	endfunction

	function automatic vga_pkg::rgb_t screen_color(input screen_e screen);
		case (screen)
			SCR_LOGO: return '{r: 8'h20, g: 8'h20, b: 8'h60};	// Navy
			SCR_READY: return '{r: 8'h00, g: 8'ha0, b: 8'ha0};	// Teal
			SCR_PLAY: return '{r: 8'h10, g: 8'h40, b: 8'h10};	// Pitch green
			SCR_TIMES_UP: return '{r: 8'ha0, g: 8'h20, b: 8'h20};	// Dark red
			default: return '{r: 8'h40, g: 8'h40, b: 8'h40};	// Board grey
		endcase
	endfunction

endpackage

// File: source/vga_pkg.sv
package vga_pkg;

	typedef logic [9:0] coord_t;	// Pixel column or row
	typedef logic [7:0] color_t;	// One colour channel

	typedef struct packed {
		color_t r;	// Red
		color_t g;	// Green
		color_t b;	// Blue
	} rgb_t;	// 24 bits

	// Raster position plus the sync state generated for it
	typedef struct packed {
		coord_t x;	// Column, counts through porches too
		coord_t y;	// Row
		logic active;	// Inside visible area
		logic hs;	// Horizontal sync, active low
		logic vs;	// Vertical sync, active low
		logic frame_start;	// High at 0,0 only
	} pixel_pos_t;	// 24 bits

	localparam rgb_t RGB_BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};	// Porches and sync
	localparam rgb_t RGB_WHITE = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage
